// ==== source/pf_cfg_pkg.sv ====
`default_nettype none

package pf_cfg_pkg;

    // fetch word address
    localparam int ADDR_W = 32;

    // tables are indexed by the low address bits, no tags
    localparam int IDX_W         = 6;
    localparam int TABLE_ENTRIES = 1 << IDX_W;

    // prefetch queue
    localparam int QUEUE_DEPTH = 4;
    localparam int QPTR_W      = $clog2(QUEUE_DEPTH);
    localparam int QCNT_W      = $clog2(QUEUE_DEPTH + 1);

    // four words per cache line
    localparam int LINE_OFS_W = 2;
    localparam int LINE_W     = ADDR_W - LINE_OFS_W;

endpackage

`default_nettype wire

// ==== source/pf_types_pkg.sv ====
`default_nettype none

package pf_types_pkg;

    import pf_cfg_pkg::*;

    // 2-bit saturating counter, upper bit is the decision
    typedef logic [1:0] ctr_t;

    localparam ctr_t CTR_STRONG_NO  = 2'b00;
    localparam ctr_t CTR_WEAK_NO    = 2'b01;
    localparam ctr_t CTR_WEAK_YES   = 2'b10;
    localparam ctr_t CTR_STRONG_YES = 2'b11;

    // next-address table entry
    typedef struct packed {
        logic [ADDR_W-1:0] next_addr;
        logic              valid;
        ctr_t              jump_ctr;
    } next_entry_t;

    localparam next_entry_t NEXT_ENTRY_RESET = '{
        next_addr: '0,
        valid:     1'b0,
        jump_ctr:  CTR_STRONG_NO
    };

    // usefulness starts just above the threshold
    localparam ctr_t USEFUL_RESET = CTR_WEAK_YES;

endpackage

`default_nettype wire

// ==== source/pf_table.sv ====
`timescale 1ns/1ps
`default_nettype none

module pf_table
    import pf_cfg_pkg::*;
#(
    parameter type    entry_t = logic [1:0],
    parameter entry_t INIT    = '0
) (
    input  logic             clk,
    input  logic             rst_n,

    input  logic [IDX_W-1:0] rd_idx,
    output entry_t           rd_data,

    input  logic             wr_en,
    input  logic [IDX_W-1:0] wr_idx,
    input  entry_t           wr_data
);

    entry_t mem [TABLE_ENTRIES];

    // whole array back to the initial entry
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < TABLE_ENTRIES; i++) begin
                mem[i] <= INIT;
            end
        end else if (wr_en) begin
            mem[wr_idx] <= wr_data;
        end
    end

    // registered read, write-first on a same-index collision
    always_ff @(posedge clk) begin
        if (wr_en && (wr_idx == rd_idx)) begin
            rd_data <= wr_data;
        end else begin
            rd_data <= mem[rd_idx];
        end
    end

    a_wr_idx_known: assert property (
        @(posedge clk) disable iff (!rst_n)
        wr_en |-> !$isunknown(wr_idx)
    );

endmodule

`default_nettype wire

// ==== source/next_line_predictor.sv ====
`timescale 1ns/1ps
`default_nettype none

module next_line_predictor
    import pf_cfg_pkg::*;
    import pf_types_pkg::*;
(
    input  logic              clk,
    input  logic              rst_n,

    input  logic              fetch_valid,
    input  logic [ADDR_W-1:0] fetch_addr,

    input  logic              useful_upd,
    input  logic [ADDR_W-1:0] useful_addr,
    input  logic              useful_hit,

    input  logic              anneal_miss,
    input  logic [ADDR_W-1:0] anneal_addr,
    input  logic              anneal_demand,

    output logic              pred_valid,
    output logic [ADDR_W-1:0] pred_addr
);

    function automatic ctr_t ctr_step(ctr_t c, logic up);
        ctr_t n;
        n = c;
        if (up) begin
            if (c != CTR_STRONG_YES) begin
                n = c + 2'd1;
            end
        end else begin
            if (c != CTR_STRONG_NO) begin
                n = c - 2'd1;
            end
        end
        return n;
    endfunction

    // lookup stage, one cycle after the fetch strobe
    logic              s1_valid;
    logic [ADDR_W-1:0] s1_addr;
    logic              s1_no_pred;

    // previous fetch and its entry, for training
    logic              last_valid;
    logic [ADDR_W-1:0] last_addr;
    next_entry_t       prev_entry;

    next_entry_t       nt_rd_data;
    next_entry_t       nt_wr_data;
    next_entry_t       cur_entry;
    logic              nt_wr_en;
    logic [IDX_W-1:0]  nt_wr_idx;
    logic              jump;

    ctr_t              ut_rd_data;
    ctr_t              ut_wr_data;
    logic [IDX_W-1:0]  ut_rd_idx;
    logic [IDX_W-1:0]  ut_wr_idx;
    logic              ut_wr_en;

    // read-modify-write of the usefulness counters
    logic              ann_rd;
    logic              ann_wr;
    logic [IDX_W-1:0]  ann_idx;
    logic              usf_rd;
    logic              usf_wr;
    logic [IDX_W-1:0]  usf_idx;
    logic              usf_hit;

    logic              pred_hit;
    logic [ADDR_W-1:0] pred_next;

    assign ann_rd = anneal_miss && !anneal_demand;
    // an anneal read or write owns the usefulness ports, the update is lost
    assign usf_rd = useful_upd && !ann_rd && !ann_wr;

    always_comb begin
        if (ann_rd) begin
            ut_rd_idx = anneal_addr[IDX_W-1:0];
        end else if (usf_rd) begin
            ut_rd_idx = useful_addr[IDX_W-1:0];
        end else begin
            ut_rd_idx = fetch_addr[IDX_W-1:0];
        end
    end

    assign ut_wr_en   = ann_wr || usf_wr;
    assign ut_wr_idx  = ann_wr ? ann_idx : usf_idx;
    assign ut_wr_data = ctr_step(ut_rd_data, !ann_wr && usf_hit);

    // training of the previous fetch's entry
    assign jump      = (s1_addr != last_addr + 1'b1);
    assign nt_wr_en  = s1_valid && last_valid;
    assign nt_wr_idx = last_addr[IDX_W-1:0];

    always_comb begin
        nt_wr_data.next_addr = s1_addr;
        nt_wr_data.valid     = 1'b1;
        if (prev_entry.valid) begin
            nt_wr_data.jump_ctr = ctr_step(prev_entry.jump_ctr, jump);
        end else begin
            nt_wr_data.jump_ctr = jump ? CTR_WEAK_YES : CTR_WEAK_NO;
        end
    end

    // aliased write in the lookup cycle
    assign cur_entry = (nt_wr_en && (nt_wr_idx == s1_addr[IDX_W-1:0])) ? nt_wr_data : nt_rd_data;

    always_comb begin
        pred_hit  = 1'b0;
        pred_next = s1_addr + 1'b1;
        if (s1_valid && !s1_no_pred) begin
            if (!cur_entry.valid) begin
                pred_hit = 1'b1;
            end else if (ut_rd_data[1]) begin
                pred_hit = 1'b1;
                if (cur_entry.jump_ctr[1]) begin
                    pred_next = cur_entry.next_addr;
                end
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            s1_valid   <= 1'b0;
            s1_no_pred <= 1'b0;
            last_valid <= 1'b0;
            ann_wr     <= 1'b0;
            usf_wr     <= 1'b0;
            pred_valid <= 1'b0;
        end else begin
            s1_valid   <= fetch_valid;
            s1_no_pred <= ann_rd || usf_rd;
            ann_wr     <= ann_rd;
            usf_wr     <= usf_rd;
            pred_valid <= pred_hit;
            if (s1_valid) begin
                last_valid <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (fetch_valid) begin
            s1_addr <= fetch_addr;
        end
        ann_idx   <= anneal_addr[IDX_W-1:0];
        usf_idx   <= useful_addr[IDX_W-1:0];
        usf_hit   <= useful_hit;
        pred_addr <= pred_next;
        if (s1_valid) begin
            last_addr  <= s1_addr;
            prev_entry <= cur_entry;
        end
    end

    pf_table #(
        .entry_t (next_entry_t),
        .INIT    (NEXT_ENTRY_RESET)
    ) i_next_table (
        .clk     (clk),
        .rst_n   (rst_n),
        .rd_idx  (fetch_addr[IDX_W-1:0]),
        .rd_data (nt_rd_data),
        .wr_en   (nt_wr_en),
        .wr_idx  (nt_wr_idx),
        .wr_data (nt_wr_data)
    );

    pf_table #(
        .entry_t (ctr_t),
        .INIT    (USEFUL_RESET)
    ) i_useful_table (
        .clk     (clk),
        .rst_n   (rst_n),
        .rd_idx  (ut_rd_idx),
        .rd_data (ut_rd_data),
        .wr_en   (ut_wr_en),
        .wr_idx  (ut_wr_idx),
        .wr_data (ut_wr_data)
    );

    a_pred_after_fetch: assert property (
        @(posedge clk) disable iff (!rst_n)
        pred_valid |-> $past(fetch_valid, 2)
    );

endmodule

`default_nettype wire

// ==== source/prefetch_queue.sv ====
`timescale 1ns/1ps
`default_nettype none

module prefetch_queue
    import pf_cfg_pkg::*;
(
    input  logic              clk,
    input  logic              rst_n,

    input  logic              push,
    input  logic [ADDR_W-1:0] push_addr,

    input  logic              pop,
    output logic [ADDR_W-1:0] head_addr,
    output logic              empty,

    output logic              drop
);

    logic [ADDR_W-1:0] mem [QUEUE_DEPTH];
    logic [QPTR_W-1:0] wr_ptr;
    logic [QPTR_W-1:0] rd_ptr;
    logic [QCNT_W-1:0] count;
    logic              full;
    logic              do_push;
    logic              do_pop;

    assign empty     = (count == '0);
    assign full      = (count == QCNT_W'(QUEUE_DEPTH));
    assign head_addr = mem[rd_ptr];

    // a pop in the same cycle frees the slot for the push
    assign do_push = push && (!full || pop);
    assign do_pop  = pop && !empty;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
            drop   <= 1'b0;
        end else begin
            drop <= push && full && !pop;
            if (do_push) begin
                if (wr_ptr == QPTR_W'(QUEUE_DEPTH - 1)) begin
                    wr_ptr <= '0;
                end else begin
                    wr_ptr <= wr_ptr + 1'b1;
                end
            end
            if (do_pop) begin
                if (rd_ptr == QPTR_W'(QUEUE_DEPTH - 1)) begin
                    rd_ptr <= '0;
                end else begin
                    rd_ptr <= rd_ptr + 1'b1;
                end
            end
            if (do_push && !do_pop) begin
                count <= count + 1'b1;
            end else if (do_pop && !do_push) begin
                count <= count - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= push_addr;
        end
    end

    a_no_pop_empty: assert property (
        @(posedge clk) disable iff (!rst_n)
        pop |-> !empty
    );

endmodule

`default_nettype wire

// ==== source/prefetch_issuer.sv ====
`timescale 1ns/1ps
`default_nettype none

module prefetch_issuer
    import pf_cfg_pkg::*;
(
    input  logic              clk,
    input  logic              rst_n,

    input  logic              q_empty,
    input  logic [ADDR_W-1:0] q_addr,
    output logic              q_pop,

    input  logic              l2_busy,
    output logic              l2_req,
    output logic [LINE_W-1:0] l2_addr
);

    logic [LINE_W-1:0] q_line;
    logic [LINE_W-1:0] last_line;
    logic              last_valid;
    logic              repeat_line;

    assign q_pop  = !q_empty && !l2_busy;
    assign q_line = q_addr[ADDR_W-1:LINE_OFS_W];

    // same line as the last one sent, no new request
    assign repeat_line = last_valid && (q_line == last_line);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            l2_req     <= 1'b0;
            last_valid <= 1'b0;
            last_line  <= '0;
        end else begin
            l2_req <= q_pop && !repeat_line;
            if (q_pop) begin
                last_valid <= 1'b1;
                last_line  <= q_line;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (q_pop) begin
            l2_addr <= q_line;
        end
    end

    a_req_not_busy: assert property (
        @(posedge clk) disable iff (!rst_n)
        l2_req |-> $past(!l2_busy)
    );

endmodule

`default_nettype wire

// ==== source/prefetch_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module prefetch_top
    import pf_cfg_pkg::*;
(
    input  logic              clk,
    input  logic              rst_n,

    input  logic              fetch_valid,
    input  logic [ADDR_W-1:0] fetch_addr,

    input  logic              useful_upd,
    input  logic [ADDR_W-1:0] useful_addr,
    input  logic              useful_hit,

    input  logic              anneal_miss,
    input  logic [ADDR_W-1:0] anneal_addr,
    input  logic              anneal_demand,

    output logic              l2_req,
    output logic [LINE_W-1:0] l2_addr,
    input  logic              l2_busy,

    output logic              pf_drop
);

    logic              pred_valid;
    logic [ADDR_W-1:0] pred_addr;
    logic              q_empty;
    logic [ADDR_W-1:0] q_addr;
    logic              q_pop;

    next_line_predictor i_predictor (
        .clk           (clk),
        .rst_n         (rst_n),
        .fetch_valid   (fetch_valid),
        .fetch_addr    (fetch_addr),
        .useful_upd    (useful_upd),
        .useful_addr   (useful_addr),
        .useful_hit    (useful_hit),
        .anneal_miss   (anneal_miss),
        .anneal_addr   (anneal_addr),
        .anneal_demand (anneal_demand),
        .pred_valid    (pred_valid),
        .pred_addr     (pred_addr)
    );

    prefetch_queue i_queue (
        .clk       (clk),
        .rst_n     (rst_n),
        .push      (pred_valid),
        .push_addr (pred_addr),
        .pop       (q_pop),
        .head_addr (q_addr),
        .empty     (q_empty),
        .drop      (pf_drop)
    );

    prefetch_issuer i_issuer (
        .clk     (clk),
        .rst_n   (rst_n),
        .q_empty (q_empty),
        .q_addr  (q_addr),
        .q_pop   (q_pop),
        .l2_busy (l2_busy),
        .l2_req  (l2_req),
        .l2_addr (l2_addr)
    );

endmodule

`default_nettype wire

// ==== verif/tb_prefetch_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_prefetch_top
    import pf_cfg_pkg::*;
();

    localparam int TIMEOUT = 20;

    logic              clk;
    logic              rst_n;
    logic              fetch_valid;
    logic [ADDR_W-1:0] fetch_addr;
    logic              useful_upd;
    logic [ADDR_W-1:0] useful_addr;
    logic              useful_hit;
    logic              anneal_miss;
    logic [ADDR_W-1:0] anneal_addr;
    logic              anneal_demand;
    logic              l2_busy;
    logic              l2_req;
    logic [LINE_W-1:0] l2_addr;
    logic              pf_drop;

    integer seed = 25945;
    int     req_latency;

    // reference model of both tables and of the issuer's line filter
    logic [ADDR_W-1:0] m_next   [TABLE_ENTRIES];
    logic              m_valid  [TABLE_ENTRIES];
    logic [1:0]        m_jump   [TABLE_ENTRIES];
    logic [1:0]        m_useful [TABLE_ENTRIES];
    logic              m_have_prev;
    logic [ADDR_W-1:0] m_prev;
    logic              m_have_line;
    logic [LINE_W-1:0] m_last_line;

    prefetch_top i_dut (
        .clk           (clk),
        .rst_n         (rst_n),
        .fetch_valid   (fetch_valid),
        .fetch_addr    (fetch_addr),
        .useful_upd    (useful_upd),
        .useful_addr   (useful_addr),
        .useful_hit    (useful_hit),
        .anneal_miss   (anneal_miss),
        .anneal_addr   (anneal_addr),
        .anneal_demand (anneal_demand),
        .l2_req        (l2_req),
        .l2_addr       (l2_addr),
        .l2_busy       (l2_busy),
        .pf_drop       (pf_drop)
    );

    always #20 clk = ~clk;

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        if (got !== exp) begin
            $display("** Error: %s is 0x%0h, expected 0x%0h", name, got, exp);
            $display("Test FAILED");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    task automatic timeout_fail(input string what);
        $display("timed out while waiting for %s", what);
        $display("Test FAILED");
        $fatal(1, "timeout");
    endtask

    function automatic logic [1:0] saturate(input logic [1:0] c, input logic up);
        if (up) begin
            return (c == 2'b11) ? c : c + 2'd1;
        end
        return (c == 2'b00) ? c : c - 2'd1;
    endfunction

    // random upper bits, index chosen by the test
    function automatic logic [ADDR_W-1:0] rand_addr(input int idx);
        logic [31:0] r;
        r = $random(seed);
        return {r[ADDR_W-1:IDX_W+2], 2'b00, idx[IDX_W-1:0]};
    endfunction

    // train the previous fetch's entry, then predict for a
    task automatic model_fetch(input logic [ADDR_W-1:0] a, output logic hit,
                               output logic [ADDR_W-1:0] pa);
        int   p;
        int   i;
        logic jump;
        p    = m_prev[IDX_W-1:0];
        i    = a[IDX_W-1:0];
        jump = (a != m_prev + 1);
        if (m_have_prev) begin
            if (m_valid[p]) begin
                m_jump[p] = saturate(m_jump[p], jump);
            end else begin
                m_jump[p] = jump ? 2'b10 : 2'b01;
            end
            m_valid[p] = 1'b1;
            m_next[p]  = a;
        end
        m_have_prev = 1'b1;
        m_prev      = a;
        hit = !m_valid[i] || m_useful[i][1];
        pa  = (m_valid[i] && m_jump[i][1]) ? m_next[i] : a + 1;
    endtask

    task automatic model_issue(input logic [ADDR_W-1:0] pa, output logic req,
                               output logic [LINE_W-1:0] line);
        line = pa[ADDR_W-1:LINE_OFS_W];
        req  = !(m_have_line && (line == m_last_line));
        m_have_line = 1'b1;
        m_last_line = line;
    endtask

    task automatic drive_fetch(input logic [ADDR_W-1:0] a);
        @(posedge clk);
        fetch_valid <= 1'b1;
        fetch_addr  <= a;
        @(posedge clk);
        fetch_valid <= 1'b0;
    endtask

    task automatic update_useful(input logic [ADDR_W-1:0] a, input logic hit);
        int i;
        i = a[IDX_W-1:0];
        m_useful[i] = saturate(m_useful[i], hit);
        @(posedge clk);
        useful_upd  <= 1'b1;
        useful_addr <= a;
        useful_hit  <= hit;
        @(posedge clk);
        useful_upd <= 1'b0;
    endtask

    task automatic send_anneal(input logic [ADDR_W-1:0] a, input logic demand);
        int i;
        i = a[IDX_W-1:0];
        if (!demand) begin
            m_useful[i] = saturate(m_useful[i], 1'b0);
        end
        @(posedge clk);
        anneal_miss   <= 1'b1;
        anneal_addr   <= a;
        anneal_demand <= demand;
        @(posedge clk);
        anneal_miss <= 1'b0;
    endtask

    task automatic wait_req();
        int   cycles;
        logic seen;
        cycles = 0;
        seen   = 1'b0;
        while (!seen && cycles < TIMEOUT) begin
            @(negedge clk);
            cycles++;
            seen = l2_req;
        end
        if (!seen) begin
            timeout_fail("l2_req");
        end
        req_latency = cycles;
    endtask

    task automatic expect_quiet(input int n);
        repeat (n) begin
            @(negedge clk);
            check_value("l2_req", l2_req, 1'b0);
        end
    endtask

    task automatic fetch_and_check(input logic [ADDR_W-1:0] a);
        logic              hit;
        logic              req;
        logic [ADDR_W-1:0] pa;
        logic [LINE_W-1:0] line;
        req = 1'b0;
        model_fetch(a, hit, pa);
        if (hit) begin
            model_issue(pa, req, line);
        end
        drive_fetch(a);
        if (req) begin
            wait_req();
            check_value("l2_addr", l2_addr, line);
        end
        expect_quiet(8);
    endtask

    task automatic test_cold_sequential();
        fetch_and_check(rand_addr(3));
        check_value("l2_req latency", req_latency, 4);
    endtask

    task automatic test_learned_jump();
        logic [ADDR_W-1:0] a;
        logic [ADDR_W-1:0] b;
        logic [ADDR_W-1:0] c;
        a = rand_addr(7);
        b = rand_addr(23);
        c = rand_addr(15);
        fetch_and_check(a);
        fetch_and_check(b);
        fetch_and_check(a);
        // two sequential trainings, c moves the filter to another line
        fetch_and_check(a + 1);
        fetch_and_check(a);
        fetch_and_check(a + 1);
        fetch_and_check(c);
        fetch_and_check(a);
    endtask

    task automatic test_usefulness();
        logic [ADDR_W-1:0] d;
        logic [ADDR_W-1:0] e;
        d = rand_addr(31);
        e = rand_addr(39);
        fetch_and_check(d);
        fetch_and_check(e);
        update_useful(d, 1'b0);
        update_useful(d, 1'b0);
        fetch_and_check(d);
        update_useful(d, 1'b1);
        update_useful(d, 1'b1);
        fetch_and_check(e);
        fetch_and_check(d);
    endtask

    task automatic test_anneal();
        logic [ADDR_W-1:0] p;
        logic [ADDR_W-1:0] q;
        p = rand_addr(19);
        q = rand_addr(27);
        fetch_and_check(p);
        fetch_and_check(q);
        send_anneal(p, 1'b1);
        send_anneal(p, 1'b1);
        fetch_and_check(p);
        send_anneal(p, 1'b0);
        send_anneal(p, 1'b0);
        fetch_and_check(q);
        fetch_and_check(p);
    endtask

    task automatic test_back_pressure();
        logic              hit;
        logic              req;
        logic [ADDR_W-1:0] a;
        logic [ADDR_W-1:0] pa;
        logic [LINE_W-1:0] line;
        logic [LINE_W-1:0] exp_lines [$];
        int                drops;
        @(posedge clk);
        l2_busy <= 1'b1;
        for (int k = 0; k < 5; k++) begin
            a = rand_addr(43 + 4 * k);
            model_fetch(a, hit, pa);
            // fifth prediction finds the queue full
            if (hit && k < QUEUE_DEPTH) begin
                model_issue(pa, req, line);
                if (req) begin
                    exp_lines.push_back(line);
                end
            end
            drive_fetch(a);
        end
        drops = 0;
        repeat (12) begin
            @(negedge clk);
            drops += pf_drop;
            check_value("l2_req", l2_req, 1'b0);
        end
        check_value("pf_drop pulses", drops, 1);
        @(posedge clk);
        l2_busy <= 1'b0;
        while (exp_lines.size() > 0) begin
            wait_req();
            check_value("l2_addr", l2_addr, exp_lines.pop_front());
        end
        expect_quiet(8);
    endtask

    task automatic test_line_filter();
        logic [ADDR_W-1:0] g;
        g = rand_addr(24);
        fetch_and_check(g);
        fetch_and_check(g + 1);
    endtask

    initial begin
        clk           = 1'b0;
        rst_n         = 1'b0;
        fetch_valid   = 1'b0;
        fetch_addr    = '0;
        useful_upd    = 1'b0;
        useful_addr   = '0;
        useful_hit    = 1'b0;
        anneal_miss   = 1'b0;
        anneal_addr   = '0;
        anneal_demand = 1'b0;
        l2_busy       = 1'b0;
        for (int i = 0; i < TABLE_ENTRIES; i++) begin
            m_next[i]   = '0;
            m_valid[i]  = 1'b0;
            m_jump[i]   = 2'b00;
            m_useful[i] = 2'b10;
        end
        m_have_prev = 1'b0;
        m_prev      = '0;
        m_have_line = 1'b0;
        m_last_line = '0;
        repeat (5) @(posedge clk);
        rst_n <= 1'b1;
        test_cold_sequential();
        test_learned_jump();
        test_usefulness();
        test_anneal();
        test_back_pressure();
        test_line_filter();
        $display("Test OK");
        $finish;
    end

endmodule

`default_nettype wire

// ==== list.f ====
source/pf_cfg_pkg.sv
source/pf_types_pkg.sv
source/pf_table.sv
source/next_line_predictor.sv
source/prefetch_queue.sv
source/prefetch_issuer.sv
source/prefetch_top.sv
verif/tb_prefetch_top.sv

// ==== run.sh ====
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    -f list.f --top-module tb_prefetch_top -o tb_prefetch_top

# the simulator exit status is ignored, the output decides
out=$(./obj_dir/tb_prefetch_top 2>&1 || true)
echo "$out"
echo "$out" | grep -qx "Test OK"
